/* compile.f */
+incdir+.
saturn_types_pkg.sv
saturn_ops_pkg.sv
alu_operand_if.sv
reg_file.sv
operand_path.sv
bcd_addsub.sv
nibble_compare.sv
alu_exec.sv
alru_top.sv
tb_alru.sv

/* tb_alru_model.svh */
// reference model of registers, latches, flags and ALU, included inside the testbench module

localparam word_t M_ONES_DEC = {NIBBLES{4'h9}};
localparam word_t M_ONES_HEX = {NIBBLES{4'hF}};

word_t    m_regs [12];                          // A-D in 0..3, R0-R7 in 4..11
logic     m_carry;
logic     m_dec;
word_t    m_op1;
word_t    m_op2;
nib_idx_t m_left;
nib_idx_t m_right;

function automatic int reg_slot(input opsel_t bank, input reg_idx_t idx);
    return (bank == SEL_ARITH) ? int'(idx[1:0]) : 4 + int'(idx);
endfunction

function automatic word_t field_bits(input nib_idx_t l, input nib_idx_t r);
    word_t m;
    m = '0;
    for (int i = 0; i < NIBBLES; i++)
    begin
        if (i >= r && i <= l)
            m[4*i +: 4] = 4'hF;
    end
    return m;
endfunction

function automatic word_t source_value(input opsel_t sel, input reg_idx_t idx,
                                       input word_t lit, input logic dec);
    case (sel)
        SEL_ARITH, SEL_SCRATCH: return m_regs[reg_slot(sel, idx)];
        SEL_LITERAL:            return lit;
        SEL_ONES:               return dec ? M_ONES_DEC : M_ONES_HEX;
        default:                return '0;
    endcase
endfunction

// digit by digit, base 10 or 16, borrow counts as carry
function automatic void addsub_model(input word_t a, input word_t b, input logic sub,
                                     input logic dec, input logic cin,
                                     input nib_idx_t cin_pos, input nib_idx_t cout_pos,
                                     output word_t q, output logic cout);
    int   d;
    int   base;
    logic c;

    base = dec ? 10 : 16;
    c    = 1'b0;
    q    = '0;
    cout = 1'b0;
    for (int i = 0; i < NIBBLES; i++)
    begin
        d = c | (cin && cin_pos == i);
        if (sub)
            d = int'(a[4*i +: 4]) - int'(b[4*i +: 4]) - d;
        else
            d = int'(a[4*i +: 4]) + int'(b[4*i +: 4]) + d;
        c = sub ? (d < 0) : (d >= base);
        if (c)
            d = sub ? d + base : d - base;
        q[4*i +: 4] = 4'(d);
        if (cout_pos == i)
            cout = c;
    end
endfunction

function automatic void alu_model(input alu_op_t op, input word_t a, input word_t b,
                                  input logic fc, input logic fh, input logic dec,
                                  input nib_idx_t l, input nib_idx_t r,
                                  output word_t q, output logic c);
    q = a;
    c = 1'b0;
    case (op)
        ALU_ADD:  addsub_model(a, b, 1'b0, dec && !fh, fc, r, l, q, c);
        ALU_SUB:  addsub_model(a, b, 1'b1, dec && !fh, fc, r, l, q, c);
        ALU_RSUB: addsub_model(b, a, 1'b1, dec, fc, r, l, q, c);   // no forced hex here
        ALU_AND:  q = a & b;
        ALU_OR:   q = a | b;
        ALU_ANDN: q = a & ~b;
        ALU_EQ:   c = (b == a);
        ALU_NEQ:  c = (b != a);
        ALU_GT:   c = (b > a);
        ALU_GTEQ: c = (b >= a);
        ALU_LT:   c = (b < a);
        ALU_LTEQ: c = (b <= a);
        default: ;
    endcase
endfunction

// one rising edge, using the inputs the DUT samples at that edge
task automatic model_edge();
    word_t q;
    logic  c;
    word_t wb;
    word_t new_op1;
    word_t new_op2;
    int    slot;

    if (reset_i)
    begin
        foreach (m_regs[i])
            m_regs[i] = '0;
        m_carry = 1'b0;
        m_dec   = 1'b0;
        m_op1   = '0;
        m_op2   = '0;
        m_left  = '0;
        m_right = '0;
    end
    else
    begin
        alu_model(alu_op_i, m_op1, m_op2, forced_carry_i, forced_hex_i, m_dec,
                  m_left, m_right, q, c);
        wb      = field_bits(left_i, right_i);
        new_op1 = source_value(op1_sel_i, op1_idx_i, literal_i, m_dec) & wb;  // old regs
        new_op2 = source_value(op2_sel_i, op2_idx_i, literal_i, m_dec) & wb;
        if (write_dst_i && (dst_sel_i == SEL_ARITH || dst_sel_i == SEL_SCRATCH))
        begin
            slot         = reg_slot(dst_sel_i, dst_idx_i);
            m_regs[slot] = (m_regs[slot] & ~wb) | (q & wb);
        end
        if (latch_i)
        begin
            m_op1   = new_op1;
            m_op2   = new_op2;
            m_left  = left_i;
            m_right = right_i;
        end
        if (clr_carry_i)
            m_carry = 1'b0;
        else if (set_carry_i)
            m_carry = 1'b1;
        else if (write_carry_i)
            m_carry = c;
        if (set_hex_i)
            m_dec = 1'b0;
        else if (set_dec_i)
            m_dec = 1'b1;
    end
endtask

/* tb_alru.sv */
// testbench for the arithmetic core, random operations checked against the reference model
`timescale 1ns/1ps

module tb_alru;
    import saturn_types_pkg::*;
    import saturn_ops_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_LOAD     = 40;
    localparam int N_ARITH    = 80;
    localparam int N_LOGIC    = 60;
    localparam int N_FLAG     = 40;
    localparam int N_OVL      = 30;
    localparam int MAX_CYCLES = 28 + N_LOAD * 4 + (N_ARITH + N_LOGIC + N_OVL) * 6
                                + N_FLAG * 3;

    logic       clk_in;
    logic       reset_i;
    logic       latch_i;
    logic       write_dst_i;
    alu_op_t    alu_op_i;
    logic       forced_carry_i;
    logic       forced_hex_i;
    logic       write_carry_i;
    logic       set_carry_i;
    logic       clr_carry_i;
    logic       set_dec_i;
    logic       set_hex_i;
    opsel_t     op1_sel_i;
    reg_idx_t   op1_idx_i;
    opsel_t     op2_sel_i;
    reg_idx_t   op2_idx_i;
    opsel_t     dst_sel_i;
    reg_idx_t   dst_idx_i;
    word_t      literal_i;
    nib_idx_t   left_i;
    nib_idx_t   right_i;
    word_t      data_o;
    logic       carry_o;
    logic       decimal_o;

    logic [31:0] rng_state = 32'h674e_0604;
    int          total_checks = 0;
    int          total_errs = 0;
    int          test_checks = 0;
    int          test_errs = 0;

    `include "tb_alru_model.svh"

    alru_top uut (.*);

    initial
    begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial
    begin
        #(MAX_CYCLES * CLK_PERIOD + 400);
        $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t rand64();
        return {rand32(), rand32()};
    endfunction

    function automatic word_t rand_bcd();
        word_t w;
        for (int i = 0; i < NIBBLES; i++)
            w[4*i +: 4] = 4'(rand32() % 10);
        return w;
    endfunction

    task automatic pick_reg(output opsel_t bank, output reg_idx_t idx);
        bank = (rand32() % 2 == 0) ? SEL_ARITH : SEL_SCRATCH;
        idx  = 3'(rand32());
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        test_checks++;
        if (got !== exp)
        begin
            test_errs++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-8s %0d checks, %0d errors", name, test_checks, test_errs);
        total_checks += test_checks;
        total_errs   += test_errs;
        test_checks  = 0;
        test_errs    = 0;
    endtask

    // advance one edge and drop all one-cycle strobes
    task automatic next_cycle();
        @(posedge clk_in);
        model_edge();
        latch_i        <= 1'b0;
        write_dst_i    <= 1'b0;
        write_carry_i  <= 1'b0;
        set_carry_i    <= 1'b0;
        clr_carry_i    <= 1'b0;
        set_dec_i      <= 1'b0;
        set_hex_i      <= 1'b0;
        forced_carry_i <= 1'b0;
        forced_hex_i   <= 1'b0;
    endtask

    task automatic drive_latch(input opsel_t s2, input reg_idx_t i2, input word_t lit,
                               input nib_idx_t l, input nib_idx_t r);
        op1_sel_i <= SEL_LITERAL;
        op2_sel_i <= s2;
        op2_idx_i <= i2;
        literal_i <= lit;
        left_i    <= l;
        right_i   <= r;
        latch_i   <= 1'b1;
    endtask

    task automatic drive_write(input alu_op_t op, input opsel_t ds, input reg_idx_t di,
                               input logic fc, input logic fh);
        alu_op_i       <= op;
        dst_sel_i      <= ds;
        dst_idx_i      <= di;
        write_dst_i    <= 1'b1;
        write_carry_i  <= 1'b1;
        forced_carry_i <= fc;
        forced_hex_i   <= fh;
    endtask

    // write-back happens at the edge that starts the following task
    task automatic run_op(input alu_op_t op, input opsel_t s2, input reg_idx_t i2,
                          input opsel_t ds, input reg_idx_t di, input word_t lit,
                          input nib_idx_t l, input nib_idx_t r, input logic fc, input logic fh);
        next_cycle();
        drive_latch(s2, i2, lit, l, r);
        next_cycle();
        drive_write(op, ds, di, fc, fh);
    endtask

    task automatic read_check(input opsel_t sel, input reg_idx_t idx);
        next_cycle();
        op1_sel_i <= sel;
        op1_idx_i <= idx;
        left_i    <= 4'hF;
        right_i   <= 4'h0;
        @(negedge clk_in);
        check(data_o, source_value(sel, idx, literal_i, m_dec), "data_o");
        check(carry_o, m_carry, "carry_o");
        check(decimal_o, m_dec, "decimal_o");
    endtask

    initial
    begin
        opsel_t   b1;
        opsel_t   b2;
        opsel_t   b3;
        reg_idx_t i1;
        reg_idx_t i2;
        reg_idx_t i3;
        word_t    w;
        logic     dec;
        alu_op_t  op;

        reset_i        = 1'b1;
        latch_i        = 1'b0;
        write_dst_i    = 1'b0;
        alu_op_i       = ALU_TFR;
        forced_carry_i = 1'b0;
        forced_hex_i   = 1'b0;
        write_carry_i  = 1'b0;
        set_carry_i    = 1'b0;
        clr_carry_i    = 1'b0;
        set_dec_i      = 1'b0;
        set_hex_i      = 1'b0;
        op1_sel_i      = SEL_ZERO;
        op1_idx_i      = '0;
        op2_sel_i      = SEL_ZERO;
        op2_idx_i      = '0;
        dst_sel_i      = SEL_ZERO;
        dst_idx_i      = '0;
        literal_i      = '0;
        left_i         = 4'hF;
        right_i        = 4'h0;

        repeat (4) next_cycle();
        reset_i <= 1'b0;
        for (int i = 0; i < 4; i++)
            read_check(SEL_ARITH, 3'(i));
        for (int i = 0; i < 8; i++)
            read_check(SEL_SCRATCH, 3'(i));
        end_test("reset");

        repeat (N_LOAD)
        begin
            pick_reg(b1, i1);
            run_op(ALU_TFR, SEL_ZERO, 3'd0, b1, i1, rand64(), 4'(rand32()), 4'(rand32()),
                   1'b0, 1'b0);
            read_check(b1, i1);
        end
        end_test("load");

        repeat (N_ARITH)
        begin
            dec = 1'(rand32());
            next_cycle();
            set_dec_i <= dec;                   // takes effect at the next edge
            set_hex_i <= !dec;
            pick_reg(b1, i1);
            pick_reg(b2, i2);
            run_op(ALU_TFR, SEL_ZERO, 3'd0, b1, i1, dec ? rand_bcd() : rand64(), 4'hF, 4'h0,
                   1'b0, 1'b0);
            op = alu_op_t'(1 + rand32() % 3);   // ADD, SUB or RSUB
            run_op(op, b1, i1, b2, i2, dec ? rand_bcd() : rand64(), 4'(rand32()),
                   4'(rand32()), 1'(rand32()), 1'(rand32()));
            read_check(b2, i2);
        end
        end_test("arith");

        repeat (N_LOGIC)
        begin
            pick_reg(b1, i1);
            pick_reg(b2, i2);
            w = rand64();
            run_op(ALU_TFR, SEL_ZERO, 3'd0, b1, i1, w, 4'hF, 4'h0, 1'b0, 1'b0);
            op = alu_op_t'(4 + rand32() % 9);
            if (rand32() % 4 != 0)
                w = rand64();                   // else equal operands
            if (op > ALU_ANDN)
                b2 = SEL_ZERO;                  // compare result only in carry
            run_op(op, b1, i1, b2, i2, w, 4'(rand32()), 4'(rand32()), 1'b0, 1'b0);
            read_check(b2, i2);
        end
        end_test("logic");

        repeat (N_FLAG)
        begin
            next_cycle();
            alu_op_i      <= alu_op_t'(rand32() % 13);
            clr_carry_i   <= 1'(rand32());
            set_carry_i   <= 1'(rand32());
            write_carry_i <= 1'(rand32());
            set_dec_i     <= 1'(rand32());
            set_hex_i     <= 1'(rand32());
            read_check(SEL_ONES, 3'd0);
        end
        end_test("flags");

        repeat (N_OVL)
        begin
            pick_reg(b1, i1);
            pick_reg(b2, i2);
            pick_reg(b3, i3);
            next_cycle();
            drive_latch(b1, i1, rand64(), 4'(rand32()), 4'(rand32()));
            next_cycle();
            drive_latch(b3, i3, rand64(), 4'(rand32()), 4'(rand32()));
            drive_write(alu_op_t'(rand32() % 7), b2, i2, 1'(rand32()), 1'b0);
            next_cycle();
            drive_write(alu_op_t'(rand32() % 7), b3, i3, 1'(rand32()), 1'b0);
            read_check(b2, i2);
            read_check(b3, i3);
        end
        end_test("overlap");

        $display("summary: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* alru_top.sv */
// top level of the arithmetic core, wires register file, operand path and ALU together
`timescale 1ns/1ps

module alru_top (
    input  logic                       clk_in,
    input  logic                       reset_i,
    input  logic                       latch_i,
    input  logic                       write_dst_i,
    input  saturn_ops_pkg::alu_op_t    alu_op_i,
    input  logic                       forced_carry_i,
    input  logic                       forced_hex_i,
    input  logic                       write_carry_i,
    input  logic                       set_carry_i,
    input  logic                       clr_carry_i,
    input  logic                       set_dec_i,
    input  logic                       set_hex_i,
    input  saturn_ops_pkg::opsel_t     op1_sel_i,
    input  saturn_types_pkg::reg_idx_t op1_idx_i,
    input  saturn_ops_pkg::opsel_t     op2_sel_i,
    input  saturn_types_pkg::reg_idx_t op2_idx_i,
    input  saturn_ops_pkg::opsel_t     dst_sel_i,
    input  saturn_types_pkg::reg_idx_t dst_idx_i,
    input  saturn_types_pkg::word_t    literal_i,
    input  saturn_types_pkg::nib_idx_t left_i,
    input  saturn_types_pkg::nib_idx_t right_i,
    output saturn_types_pkg::word_t    data_o,
    output logic                       carry_o,
    output logic                       decimal_o
);
    import saturn_types_pkg::*;
    import saturn_ops_pkg::*;

    opsel_t    rd1_bank;
    opsel_t    rd2_bank;
    reg_idx_t  rd1_idx;
    reg_idx_t  rd2_idx;
    word_t     rd1;
    word_t     rd2;
    nib_mask_t wr_mask;
    word_t     alu_q;

    alu_operand_if opnd_if ();

    reg_file u_regs (
        .clk_in     (clk_in),
        .reset_i    (reset_i),
        .rd1_bank_i (rd1_bank),
        .rd2_bank_i (rd2_bank),
        .rd1_idx_i  (rd1_idx),
        .rd2_idx_i  (rd2_idx),
        .rd1_o      (rd1),
        .rd2_o      (rd2),
        .wr_en_i    (write_dst_i),
        .wr_bank_i  (dst_sel_i),
        .wr_idx_i   (dst_idx_i),
        .wr_mask_i  (wr_mask),
        .wr_data_i  (alu_q)
    );

    operand_path u_opnd (
        .clk_in     (clk_in),
        .reset_i    (reset_i),
        .latch_i    (latch_i),
        .op1_sel_i  (op1_sel_i),
        .op2_sel_i  (op2_sel_i),
        .op1_idx_i  (op1_idx_i),
        .op2_idx_i  (op2_idx_i),
        .literal_i  (literal_i),
        .left_i     (left_i),
        .right_i    (right_i),
        .decimal_i  (decimal_o),
        .rd1_i      (rd1),
        .rd2_i      (rd2),
        .rd1_bank_o (rd1_bank),
        .rd2_bank_o (rd2_bank),
        .rd1_idx_o  (rd1_idx),
        .rd2_idx_o  (rd2_idx),
        .wr_mask_o  (wr_mask),
        .data_o     (data_o),
        .opnd       (opnd_if.src)
    );

    alu_exec u_alu (
        .clk_in         (clk_in),
        .reset_i        (reset_i),
        .opnd           (opnd_if.alu),
        .alu_op_i       (alu_op_i),
        .forced_carry_i (forced_carry_i),
        .forced_hex_i   (forced_hex_i),
        .write_carry_i  (write_carry_i),
        .set_carry_i    (set_carry_i),
        .clr_carry_i    (clr_carry_i),
        .set_dec_i      (set_dec_i),
        .set_hex_i      (set_hex_i),
        .q_o            (alu_q),
        .carry_o        (carry_o),
        .decimal_o      (decimal_o)
    );

endmodule

/* alu_exec.sv */
// ALU operation decode, result and carry select, carry and decimal flag registers
`timescale 1ns/1ps

module alu_exec (
    input  logic                     clk_in,
    input  logic                     reset_i,
    alu_operand_if.alu               opnd,
    input  saturn_ops_pkg::alu_op_t  alu_op_i,
    input  logic                     forced_carry_i,
    input  logic                     forced_hex_i,
    input  logic                     write_carry_i,
    input  logic                     set_carry_i,
    input  logic                     clr_carry_i,
    input  logic                     set_dec_i,
    input  logic                     set_hex_i,
    output saturn_types_pkg::word_t  q_o,
    output logic                     carry_o,
    output logic                     decimal_o
);
    import saturn_types_pkg::*;
    import saturn_ops_pkg::*;

    logic  is_rsub;
    logic  add_sub;
    logic  add_dec;
    word_t add_a;
    word_t add_b;
    word_t sum_q;
    logic  sum_c;
    logic  cmp_eq;
    logic  cmp_gt;
    logic  cmp_lt;
    logic  alu_carry;
    logic  carry_q;
    logic  decimal_q;

    assign is_rsub = (alu_op_i == ALU_RSUB);
    assign add_sub = (alu_op_i == ALU_SUB) || is_rsub;
    assign add_a   = is_rsub ? opnd.op2 : opnd.op1;     // shared subtractor, swapped
    assign add_b   = is_rsub ? opnd.op1 : opnd.op2;
    assign add_dec = decimal_q && !(forced_hex_i && !is_rsub);

    bcd_addsub u_addsub (
        .a_i        (add_a),
        .b_i        (add_b),
        .sub_i      (add_sub),
        .dec_i      (add_dec),
        .cin_i      (forced_carry_i),
        .cin_pos_i  (opnd.right),
        .cout_pos_i (opnd.left),
        .q_o        (sum_q),
        .cout_o     (sum_c)
    );

    nibble_compare u_cmp (
        .a_i  (opnd.op2),
        .b_i  (opnd.op1),
        .eq_o (cmp_eq),
        .gt_o (cmp_gt),
        .lt_o (cmp_lt)
    );

    always_comb
    begin
        q_o       = opnd.op1;                   // TFR and compares
        alu_carry = 1'b0;
        case (alu_op_i)
            ALU_ADD, ALU_SUB, ALU_RSUB:
            begin
                q_o       = sum_q;
                alu_carry = sum_c;
            end
            ALU_AND:  q_o = opnd.op1 & opnd.op2;
            ALU_OR:   q_o = opnd.op1 | opnd.op2;
            ALU_ANDN: q_o = opnd.op1 & ~opnd.op2;
            ALU_EQ:   alu_carry = cmp_eq;
            ALU_NEQ:  alu_carry = !cmp_eq;
            ALU_GT:   alu_carry = cmp_gt;
            ALU_GTEQ: alu_carry = cmp_gt | cmp_eq;
            ALU_LT:   alu_carry = cmp_lt;
            ALU_LTEQ: alu_carry = cmp_lt | cmp_eq;
            default: ;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_i)
        begin
            carry_q   <= 1'b0;
            decimal_q <= 1'b0;                  // start in hex
        end
        else
        begin
            if (clr_carry_i)
                carry_q <= 1'b0;
            else if (set_carry_i)
                carry_q <= 1'b1;
            else if (write_carry_i)
                carry_q <= alu_carry;
            if (set_hex_i)
                decimal_q <= 1'b0;
            else if (set_dec_i)
                decimal_q <= 1'b1;
        end
    end

    assign carry_o   = carry_q;
    assign decimal_o = decimal_q;

endmodule

/* nibble_compare.sv */
// magnitude compare of two words, first unequal nibble from the top decides
`timescale 1ns/1ps

module nibble_compare (
    input  saturn_types_pkg::word_t a_i,
    input  saturn_types_pkg::word_t b_i,
    output logic                    eq_o,
    output logic                    gt_o,
    output logic                    lt_o
);
    import saturn_types_pkg::*;

    always_comb
    begin
        gt_o = 1'b0;
        lt_o = 1'b0;
        for (int i = NIBBLES - 1; i >= 0; i--)
        begin
            if (!gt_o && !lt_o)                 // still undecided
            begin
                if (a_i[4*i +: 4] > b_i[4*i +: 4])
                    gt_o = 1'b1;
                else if (a_i[4*i +: 4] < b_i[4*i +: 4])
                    lt_o = 1'b1;
            end
        end
        eq_o = !gt_o && !lt_o;
    end

endmodule

/* bcd_addsub.sv */
// 16-digit ripple adder-subtractor, decimal or hex, with forced carry and field carry-out
`timescale 1ns/1ps

module bcd_addsub (
    input  saturn_types_pkg::word_t    a_i,
    input  saturn_types_pkg::word_t    b_i,
    input  logic                       sub_i,
    input  logic                       dec_i,
    input  logic                       cin_i,
    input  saturn_types_pkg::nib_idx_t cin_pos_i,   // digit taking the forced carry
    input  saturn_types_pkg::nib_idx_t cout_pos_i,  // digit whose carry is reported
    output saturn_types_pkg::word_t    q_o,
    output logic                       cout_o
);
    import saturn_types_pkg::*;

    always_comb
    begin : digit_chain
        logic       carry;
        logic       cin_d;
        logic [4:0] raw;
        logic [3:0] digit;

        carry  = 1'b0;
        cout_o = 1'b0;
        q_o    = '0;
        for (int i = 0; i < NIBBLES; i++)
        begin
            cin_d = carry | (cin_i && (cin_pos_i == nib_idx_t'(i)));
            if (sub_i)
            begin
                raw   = {1'b0, a_i[4*i +: 4]} - {1'b0, b_i[4*i +: 4]} - {4'h0, cin_d};
                carry = raw[4];                             // borrow
                digit = (dec_i && carry) ? raw[3:0] - 4'h6 : raw[3:0];
            end
            else
            begin
                raw   = {1'b0, a_i[4*i +: 4]} + {1'b0, b_i[4*i +: 4]} + {4'h0, cin_d};
                carry = dec_i ? (raw > 5'd9) : raw[4];
                digit = (dec_i && carry) ? raw[3:0] + 4'h6 : raw[3:0];
            end
            q_o[4*i +: 4] = digit;
            if (cout_pos_i == nib_idx_t'(i))
                cout_o = carry;
        end
    end

endmodule

/* operand_path.sv */
// field mask decode, operand select and mask, and the operand latches feeding the ALU
`timescale 1ns/1ps

module operand_path (
    input  logic                        clk_in,
    input  logic                        reset_i,
    input  logic                        latch_i,
    input  saturn_ops_pkg::opsel_t      op1_sel_i,
    input  saturn_ops_pkg::opsel_t      op2_sel_i,
    input  saturn_types_pkg::reg_idx_t  op1_idx_i,
    input  saturn_types_pkg::reg_idx_t  op2_idx_i,
    input  saturn_types_pkg::word_t     literal_i,
    input  saturn_types_pkg::nib_idx_t  left_i,
    input  saturn_types_pkg::nib_idx_t  right_i,
    input  logic                        decimal_i,
    input  saturn_types_pkg::word_t     rd1_i,
    input  saturn_types_pkg::word_t     rd2_i,
    output saturn_ops_pkg::opsel_t      rd1_bank_o,
    output saturn_ops_pkg::opsel_t      rd2_bank_o,
    output saturn_types_pkg::reg_idx_t  rd1_idx_o,
    output saturn_types_pkg::reg_idx_t  rd2_idx_o,
    output saturn_types_pkg::nib_mask_t wr_mask_o,
    output saturn_types_pkg::word_t     data_o,
    alu_operand_if.src                  opnd
);
    import saturn_types_pkg::*;
    import saturn_ops_pkg::*;

    nib_mask_t field_mask;
    word_t     field_bits;
    word_t     op1_raw;
    word_t     op2_raw;
    word_t     op1_masked;
    word_t     op2_masked;

    function automatic word_t pick_operand(input opsel_t sel, input word_t rd,
                                           input word_t lit, input logic dec);
        case (sel)
            SEL_ARITH, SEL_SCRATCH: return rd;
            SEL_LITERAL:            return lit;
            SEL_ONES:               return dec ? ONES_DEC : ONES_HEX;
            default:                return '0;
        endcase
    endfunction

    // right > left leaves the mask empty
    always_comb
    begin
        for (int i = 0; i < NIBBLES; i++)
        begin
            field_mask[i] = (nib_idx_t'(i) >= right_i) && (nib_idx_t'(i) <= left_i);
        end
    end

    assign field_bits = nib_to_bits(field_mask);
    assign wr_mask_o  = field_mask;             // live field, used at write-back

    assign rd1_bank_o = op1_sel_i;
    assign rd2_bank_o = op2_sel_i;
    assign rd1_idx_o  = op1_idx_i;
    assign rd2_idx_o  = op2_idx_i;

    assign op1_raw    = pick_operand(op1_sel_i, rd1_i, literal_i, decimal_i);
    assign op2_raw    = pick_operand(op2_sel_i, rd2_i, literal_i, decimal_i);
    assign op1_masked = op1_raw & field_bits;
    assign op2_masked = op2_raw & field_bits;
    assign data_o     = op1_masked;             // memory write port

    always_ff @(posedge clk_in)
    begin
        if (reset_i)
        begin
            opnd.op1   <= '0;
            opnd.op2   <= '0;
            opnd.left  <= '0;
            opnd.right <= '0;
        end
        else if (latch_i)
        begin
            opnd.op1   <= op1_masked;
            opnd.op2   <= op2_masked;
            opnd.left  <= left_i;
            opnd.right <= right_i;
        end
    end

endmodule

/* reg_file.sv */
// register storage for A-D and R0-R7, two read ports and one nibble-masked write port
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk_in,
    input  logic                     reset_i,
    input  saturn_ops_pkg::opsel_t   rd1_bank_i,
    input  saturn_ops_pkg::opsel_t   rd2_bank_i,
    input  saturn_types_pkg::reg_idx_t  rd1_idx_i,
    input  saturn_types_pkg::reg_idx_t  rd2_idx_i,
    output saturn_types_pkg::word_t     rd1_o,
    output saturn_types_pkg::word_t     rd2_o,
    input  logic                        wr_en_i,
    input  saturn_ops_pkg::opsel_t      wr_bank_i,
    input  saturn_types_pkg::reg_idx_t  wr_idx_i,
    input  saturn_types_pkg::nib_mask_t wr_mask_i,
    input  saturn_types_pkg::word_t     wr_data_i
);
    import saturn_types_pkg::*;
    import saturn_ops_pkg::*;

    word_t abcd [ARITH_REGS];
    word_t r    [SCRATCH_REGS];
    word_t wr_bits;

    function automatic word_t read_port(input opsel_t bank, input reg_idx_t idx);
        case (bank)
            SEL_ARITH:   return abcd[idx[1:0]];
            SEL_SCRATCH: return r[idx];
            default:     return '0;         // not a register bank
        endcase
    endfunction

    always_comb
    begin
        rd1_o = read_port(rd1_bank_i, rd1_idx_i);
        rd2_o = read_port(rd2_bank_i, rd2_idx_i);
    end

    assign wr_bits = nib_to_bits(wr_mask_i);

    always_ff @(posedge clk_in)
    begin
        if (reset_i)
        begin
            foreach (abcd[i]) abcd[i] <= '0;
            foreach (r[i]) r[i] <= '0;
        end
        else if (wr_en_i)
        begin
            case (wr_bank_i)
                SEL_ARITH:
                    abcd[wr_idx_i[1:0]] <= (abcd[wr_idx_i[1:0]] & ~wr_bits) | (wr_data_i & wr_bits);
                SEL_SCRATCH:
                    r[wr_idx_i] <= (r[wr_idx_i] & ~wr_bits) | (wr_data_i & wr_bits);
                default: ;                  // other banks have no storage
            endcase
        end
    end

endmodule

/* alu_operand_if.sv */
// latched operand bundle between the operand path and the ALU
`timescale 1ns/1ps

interface alu_operand_if;
    import saturn_types_pkg::*;

    word_t    op1;                              // masked source
    word_t    op2;
    nib_idx_t left;                             // field at latch time
    nib_idx_t right;

    modport src (
        output op1, op2, left, right
    );

    modport alu (
        input  op1, op2, left, right
    );

endinterface

/* saturn_ops_pkg.sv */
// ALU operation codes and operand/destination selector codes of the arithmetic core
package saturn_ops_pkg;

    typedef enum logic [4:0] {
        ALU_TFR  = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_RSUB = 5'd3,                        // op2 - op1
        ALU_AND  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_ANDN = 5'd6,
        ALU_EQ   = 5'd7,
        ALU_NEQ  = 5'd8,
        ALU_GT   = 5'd9,
        ALU_GTEQ = 5'd10,
        ALU_LT   = 5'd11,
        ALU_LTEQ = 5'd12
    } alu_op_t;

    typedef logic [2:0] opsel_t;

    localparam opsel_t SEL_ARITH   = 3'b000;
    localparam opsel_t SEL_SCRATCH = 3'b001;
    localparam opsel_t SEL_LITERAL = 3'b011;
    localparam opsel_t SEL_ONES    = 3'b110;
    localparam opsel_t SEL_ZERO    = 3'b111;

    localparam saturn_types_pkg::word_t ONES_DEC = 64'h9999_9999_9999_9999;
    localparam saturn_types_pkg::word_t ONES_HEX = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage

/* saturn_types_pkg.sv */
// datapath widths and word types, imported by every RTL file of the arithmetic core
package saturn_types_pkg;

    localparam int NIBBLES      = 16;
    localparam int WORD_W       = 4 * NIBBLES;
    localparam int ARITH_REGS   = 4;            // A to D
    localparam int SCRATCH_REGS = 8;            // R0 to R7

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [3:0]         nib_idx_t;      // field bound, digit 0 is rightmost
    typedef logic [NIBBLES-1:0] nib_mask_t;
    typedef logic [2:0]         reg_idx_t;

    // spread a per-nibble enable over the four bits of each digit
    function automatic word_t nib_to_bits(input nib_mask_t m);
        word_t bits;
        for (int i = 0; i < NIBBLES; i++)
        begin
            bits[4*i +: 4] = {4{m[i]}};
        end
        return bits;
    endfunction

endpackage
